/* logic/linkPkg.sv */
`default_nettype none

package linkPkg;

	// ------------------------------------------------------------
	// Serial line
	// ------------------------------------------------------------
	localparam int ClocksPerBit = 8;	// Clock cycles per UART bit
	localparam int ByteWidth = 8;

	// ------------------------------------------------------------
	// Command frame, sent MSB first over the line
	// ------------------------------------------------------------
	localparam int CmdBytes = 7;
	localparam int CmdWidth = CmdBytes * ByteWidth;
	localparam int RespBytes = 4;	// One read word, LSB first

	typedef enum logic [ByteWidth-1:0] {
		OpWrite = 8'h00,
		OpRead = 8'h02
	} opcode_t;

	// First byte on the line lands in op
	typedef struct packed {
		logic [ByteWidth-1:0] op;
		logic [ByteWidth-1:0] addr;
		logic [4*ByteWidth-1:0] data;
		logic [ByteWidth-1:0] count;
	} cmdWord_t;

endpackage

`default_nettype wire

/* logic/storePkg.sv */
`default_nettype none

package storePkg;

	// Block store geometry
	localparam int AddrWidth = 8;
	localparam int Depth = 1 << AddrWidth;	// 256 blocks
	localparam int WordWidth = 32;

	typedef logic [AddrWidth-1:0] addr_t;	// Wraps modulo Depth
	typedef logic [WordWidth-1:0] word_t;

endpackage

`default_nettype wire

/* logic/storeIf.sv */
`default_nettype none

interface storeIf import storePkg::*; ();

	addr_t addr;	// Shared by reads and writes
	logic wrEn;
	word_t wrData;
	logic rdEn;	// Never high together with wrEn
	word_t rdData;	// Valid the cycle after rdEn

	// Command engine side
	modport engine (
		output addr,
		output wrEn,
		output wrData,
		output rdEn,
		input rdData
	);

	// Memory side
	modport store (
		input addr,
		input wrEn,
		input wrData,
		input rdEn,
		output rdData
	);

endinterface

`default_nettype wire

/* logic/uartLink.sv */
`default_nettype none

module uartLink import linkPkg::*; (
	input wire logic sys_clk_p,
	input wire logic rstN,
	input wire logic rxd,
	output logic txd,
	output logic [ByteWidth-1:0] rxData,
	output logic rxValid,
	input wire logic [ByteWidth-1:0] txData,
	input wire logic txValid,
	output logic txReady
);
	typedef logic [$clog2(ClocksPerBit)-1:0] bitCnt_t;
	typedef logic [$clog2(ByteWidth)-1:0] bitIdx_t;
	typedef logic [$clog2(ByteWidth+2)-1:0] frameIdx_t;
	typedef enum logic [2:0] {RxIdle, RxStart, RxData, RxStop, RxTail} rxState_t;
	typedef enum logic {TxIdle, TxSend} txState_t;

	logic rxMeta;
	logic rxSync;
	rxState_t rxState;
	bitCnt_t rxCnt;
	bitIdx_t rxBit;
	logic rxStopOk;
	logic rxSample;
	logic [ByteWidth-1:0] rxShift;

	txState_t txState;
	bitCnt_t txCnt;
	frameIdx_t txBit;
	logic [ByteWidth+1:0] txShift;	// Stop, data, start

	// ------------------------------------------------------------
	// Receiver
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end else begin
			rxMeta <= rxd;
			rxSync <= rxMeta;
		end
	end

	assign rxSample = (rxState == RxData) && (rxCnt == bitCnt_t'(ClocksPerBit - 1));

	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			rxState <= RxIdle;
			rxCnt <= '0;
			rxBit <= '0;
			rxStopOk <= 1'b0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			case (rxState)
				RxIdle: begin
					rxCnt <= '0;
					if (!rxSync)
						rxState <= RxStart;
				end
				RxStart: begin	// Walk to the middle of the start bit
					if (rxCnt == bitCnt_t'(ClocksPerBit / 2 - 1)) begin
						rxCnt <= '0;
						rxBit <= '0;
						rxState <= rxSync ? RxIdle : RxData;	// High again means a glitch
					end else
						rxCnt <= rxCnt + 1'b1;
				end
				RxData: begin
					rxCnt <= rxCnt + 1'b1;
					if (rxSample) begin
						rxBit <= rxBit + 1'b1;
						if (rxBit == bitIdx_t'(ByteWidth - 1))
							rxState <= RxStop;
					end
				end
				RxStop: begin
					rxCnt <= rxCnt + 1'b1;
					if (rxCnt == bitCnt_t'(ClocksPerBit - 1)) begin
						rxStopOk <= rxSync;
						rxCnt <= '0;
						rxState <= RxTail;
					end
				end
				RxTail: begin
					// Leave early enough to catch a back-to-back start bit
					if (rxCnt == bitCnt_t'(ClocksPerBit / 2 - 2)) begin
						rxValid <= rxStopOk;	// Bad stop bit drops the byte
						rxState <= RxIdle;
					end else
						rxCnt <= rxCnt + 1'b1;
				end
				default: rxState <= RxIdle;
			endcase
		end
	end

	always_ff @(posedge sys_clk_p) begin
		if (rxSample)
			rxShift <= {rxSync, rxShift[ByteWidth-1:1]};	// LSB arrives first
	end

	assign rxData = rxShift;

	// ------------------------------------------------------------
	// Transmitter
	// ------------------------------------------------------------
	assign txReady = (txState == TxIdle);
	assign txd = txShift[0];

	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			txState <= TxIdle;
			txShift <= '1;	// Line idles high
			txCnt <= '0;
			txBit <= '0;
		end else begin
			case (txState)
				TxIdle: if (txValid) begin
					txShift <= {1'b1, txData, 1'b0};
					txCnt <= '0;
					txBit <= '0;
					txState <= TxSend;
				end
				TxSend: if (txCnt == bitCnt_t'(ClocksPerBit - 1)) begin
					txCnt <= '0;
					txShift <= {1'b1, txShift[ByteWidth+1:1]};
					txBit <= txBit + 1'b1;
					if (txBit == frameIdx_t'(ByteWidth + 1))	// Stop bit done
						txState <= TxIdle;
				end else
					txCnt <= txCnt + 1'b1;
				default: txState <= TxIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/shiftRound.sv */
`default_nettype none

module shiftRound #(
	parameter int InWidth = 8,
	parameter int OutWidth = 56,
	parameter bit MsbFirst = 1'b1
) (
	input wire logic sys_clk_p,
	input wire logic rstN,
	input wire logic [InWidth-1:0] inData,
	input wire logic inValid,
	output logic inReady,
	output logic [OutWidth-1:0] outData,
	output logic outValid,
	input wire logic outReady
);

	generate
		if (OutWidth > InWidth) begin : genPack
			// ------------------------------------------------------------
			// Narrow beats in, one wide word out
			// ------------------------------------------------------------
			typedef logic [$clog2(OutWidth / InWidth)-1:0] beat_t;

			logic [OutWidth-1:0] wordBuf;
			beat_t beatCnt;
			logic full;

			assign inReady = !full;	// Refuse beats only while the word waits
			assign outValid = full;
			assign outData = wordBuf;

			always_ff @(posedge sys_clk_p) begin
				if (!rstN) begin
					full <= 1'b0;
					beatCnt <= '0;
				end else if (inValid && inReady) begin
					if (beatCnt == beat_t'(OutWidth / InWidth - 1)) begin
						beatCnt <= '0;
						full <= 1'b1;
					end else
						beatCnt <= beatCnt + 1'b1;
				end else if (outValid && outReady)
					full <= 1'b0;
			end

			always_ff @(posedge sys_clk_p) begin
				if (inValid && inReady)
					wordBuf <= MsbFirst ? {wordBuf[OutWidth-InWidth-1:0], inData}
						: {inData, wordBuf[OutWidth-1:InWidth]};
			end
		end else begin : genUnpack
			// ------------------------------------------------------------
			// One wide word in, narrow beats out
			// ------------------------------------------------------------
			typedef logic [$clog2(InWidth / OutWidth)-1:0] beat_t;

			logic [InWidth-1:0] wordBuf;
			beat_t beatCnt;
			logic busy;

			assign inReady = !busy;
			assign outValid = busy;
			assign outData = MsbFirst ? wordBuf[InWidth-1 -: OutWidth] : wordBuf[OutWidth-1:0];

			always_ff @(posedge sys_clk_p) begin
				if (!rstN) begin
					busy <= 1'b0;
					beatCnt <= '0;
				end else if (inValid && inReady) begin
					busy <= 1'b1;
					beatCnt <= '0;
				end else if (outValid && outReady) begin
					beatCnt <= beatCnt + 1'b1;
					if (beatCnt == beat_t'(InWidth / OutWidth - 1))
						busy <= 1'b0;	// Last beat taken
				end
			end

			always_ff @(posedge sys_clk_p) begin
				if (inValid && inReady)
					wordBuf <= inData;
				else if (outValid && outReady)
					wordBuf <= MsbFirst ? (wordBuf << OutWidth) : (wordBuf >> OutWidth);
			end
		end
	endgenerate

endmodule

`default_nettype wire

/* logic/cmdEngine.sv */
`default_nettype none

module cmdEngine import linkPkg::*, storePkg::*; (
	input wire logic sys_clk_p,
	input wire logic rstN,
	input wire cmdWord_t cmd,
	input wire logic cmdValid,
	output logic cmdReady,
	output word_t resp,
	output logic respValid,
	input wire logic respReady,
	storeIf.engine mem
);
	typedef enum logic [2:0] {Idle, Write, ReadIssue, ReadWait, Respond} state_t;

	state_t state;
	logic [ByteWidth-1:0] blocksLeft;
	addr_t curAddr;
	word_t curData;
	word_t respWord;
	logic lastBlock;

	// ------------------------------------------------------------
	// Outputs straight from the state
	// ------------------------------------------------------------
	assign cmdReady = (state == Idle);
	assign respValid = (state == Respond);
	assign resp = respWord;

	assign mem.addr = curAddr;
	assign mem.wrData = curData;
	assign mem.wrEn = (state == Write);
	assign mem.rdEn = (state == ReadIssue);

	assign lastBlock = (blocksLeft == ByteWidth'(1));

	// ------------------------------------------------------------
	// Sequencer
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (!rstN) begin
			state <= Idle;
			blocksLeft <= '0;
		end else begin
			case (state)
				Idle: if (cmdValid) begin
					blocksLeft <= cmd.count;
					if (cmd.count == '0)
						state <= Idle;	// Nothing to do
					else begin
						case (cmd.op)
							OpWrite: state <= Write;
							OpRead: state <= ReadIssue;
							default: state <= Idle;	// Unknown opcode dropped
						endcase
					end
				end
				Write: begin	// One block per cycle
					blocksLeft <= blocksLeft - 1'b1;
					if (lastBlock)
						state <= Idle;
				end
				ReadIssue: state <= ReadWait;
				ReadWait: state <= Respond;
				Respond: if (respReady) begin
					blocksLeft <= blocksLeft - 1'b1;
					state <= lastBlock ? Idle : ReadIssue;
				end
				default: state <= Idle;
			endcase
		end
	end

	// Address, data and response word
	always_ff @(posedge sys_clk_p) begin
		case (state)
			Idle: if (cmdValid) begin
				curAddr <= cmd.addr;
				curData <= cmd.data;
			end
			Write: begin
				curAddr <= curAddr + 1'b1;	// Wraps modulo Depth
				curData <= curData + 1'b1;
			end
			ReadIssue: curAddr <= curAddr + 1'b1;
			ReadWait: respWord <= mem.rdData;	// Store data valid now
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* logic/blockStore.sv */
`default_nettype none

module blockStore import storePkg::*; (
	input wire logic sys_clk_p,
	storeIf.store mem
);

	word_t ram [Depth];

	// ------------------------------------------------------------
	// Single port, write and registered read
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk_p) begin
		if (mem.wrEn)
			ram[mem.addr] <= mem.wrData;
	end

	// Holds the last word read until the next rdEn
	always_ff @(posedge sys_clk_p) begin
		if (mem.rdEn)
			mem.rdData <= ram[mem.addr];
	end

endmodule

`default_nettype wire

/* logic/oramHarnessTop.sv */
`default_nettype none

module oramHarnessTop import linkPkg::*, storePkg::*; (
	input wire logic sys_clk_p,
	input wire logic rstN,
	input wire logic uartRxd,
	output logic uartTxd
);

	logic [ByteWidth-1:0] rxByte;
	logic rxValid;
	cmdWord_t cmdWord;
	logic cmdValid;
	logic cmdReady;
	word_t respWord;
	logic respValid;
	logic respReady;
	logic [ByteWidth-1:0] txByte;
	logic txValid;
	logic txReady;

	storeIf storeBus ();

	// ------------------------------------------------------------
	// Serial side
	// ------------------------------------------------------------
	uartLink uart (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.rxd(uartRxd),
		.txd(uartTxd),
		.rxData(rxByte),
		.rxValid(rxValid),
		.txData(txByte),
		.txValid(txValid),
		.txReady(txReady)
	);

	// Receiver cannot stall, so a refused byte is simply lost
	shiftRound #(.InWidth(ByteWidth), .OutWidth(CmdWidth), .MsbFirst(1'b1)) cmdShift (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.inData(rxByte),
		.inValid(rxValid),
		.inReady(),
		.outData(cmdWord),
		.outValid(cmdValid),
		.outReady(cmdReady)
	);

	shiftRound #(.InWidth(RespBytes * ByteWidth), .OutWidth(ByteWidth), .MsbFirst(1'b0)) respShift (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.inData(respWord),
		.inValid(respValid),
		.inReady(respReady),
		.outData(txByte),
		.outValid(txValid),
		.outReady(txReady)
	);

	// ------------------------------------------------------------
	// Command engine and block store
	// ------------------------------------------------------------
	cmdEngine engine (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.cmd(cmdWord),
		.cmdValid(cmdValid),
		.cmdReady(cmdReady),
		.resp(respWord),
		.respValid(respValid),
		.respReady(respReady),
		.mem(storeBus.engine)
	);

	blockStore store (
		.sys_clk_p(sys_clk_p),
		.mem(storeBus.store)
	);

endmodule

`default_nettype wire

/* tb/harness_assertions.sv */
`default_nettype none

module harnessAssertions import linkPkg::*, storePkg::*; (
	input wire logic sys_clk_p,
	input wire logic rstN,
	input wire cmdWord_t cmd,
	input wire logic cmdValid,
	input wire logic cmdReady,
	input wire addr_t addr,
	input wire logic wrEn,
	input wire word_t wrData,
	input wire word_t resp,
	input wire logic respValid,
	input wire logic respReady
);

	int failCount = 0;	// Failures seen so far

	// ------------------------------------------------------------
	// Store port and handshake rules
	// ------------------------------------------------------------
	// Back-to-back writes step address and data by one
	assert property (@(posedge sys_clk_p) disable iff (!rstN)
		wrEn && $past(wrEn) |-> addr == addr_t'($past(addr) + 1'b1)
			&& wrData == word_t'($past(wrData) + 1'b1))
	else begin
		$error("write burst did not step address and data by one");
		failCount++;
	end

	// Response held and stable until taken
	assert property (@(posedge sys_clk_p) disable iff (!rstN)
		respValid && !respReady |=> respValid && $stable(resp))
	else begin
		$error("respValid dropped or resp changed before respReady");
		failCount++;
	end

	// An accepted write or read keeps the engine busy
	assert property (@(posedge sys_clk_p) disable iff (!rstN)
		cmdValid && cmdReady && cmd.count != '0
			&& (cmd.op == OpWrite || cmd.op == OpRead) |=> !cmdReady)
	else begin
		$error("cmdReady high right after a command with work");
		failCount++;
	end

endmodule

bind cmdEngine harnessAssertions chk (
	.sys_clk_p(sys_clk_p),
	.rstN(rstN),
	.cmd(cmd),
	.cmdValid(cmdValid),
	.cmdReady(cmdReady),
	.addr(mem.addr),
	.wrEn(mem.wrEn),
	.wrData(mem.wrData),
	.resp(resp),
	.respValid(respValid),
	.respReady(respReady)
);

`default_nettype wire

/* tb/harnessTb.sv */
`default_nettype none

module harnessTb import linkPkg::*, storePkg::*; ();

	localparam int ClkPeriod = 10;
	localparam int MaxTests = 16;
	localparam int MaxWords = 8;
	localparam int QuietCycles = 4 * 10 * ClocksPerBit;	// Four idle frames
	localparam logic [31:0] Seed = 32'd73487;

	logic sys_clk_p;
	logic rstN;
	logic uartRxd;
	logic uartTxd;
	logic tableReady;
	logic [31:0] lcgState;

	// Command table and reference model
	string tName [MaxTests];
	logic [ByteWidth-1:0] tOp [MaxTests];
	addr_t tAddr [MaxTests];
	word_t tData [MaxTests];
	logic [ByteWidth-1:0] tCount [MaxTests];
	word_t tExp [MaxTests][MaxWords];
	int numTests;
	word_t modelMem [Depth];

	logic [ByteWidth-1:0] respQueue [$];	// Bytes seen on uartTxd

	oramHarnessTop dut (
		.sys_clk_p(sys_clk_p),
		.rstN(rstN),
		.uartRxd(uartRxd),
		.uartTxd(uartTxd)
	);

	initial begin
		sys_clk_p = 1'b0;
		forever #(ClkPeriod / 2) sys_clk_p = ~sys_clk_p;
	end

	// ------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------
	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkWord(input string name, input word_t expected, input word_t actual);
		if (actual !== expected)
			abortRun($sformatf("Error: %s expected %h actual %h", name, expected, actual));
	endtask

	function automatic word_t nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	// Appends one entry and runs it through the model
	task automatic addEntry(input string name, input logic [ByteWidth-1:0] op, input addr_t addr,
			input word_t data, input logic [ByteWidth-1:0] count);
		int i;
		tName[numTests] = name;
		tOp[numTests] = op;
		tAddr[numTests] = addr;
		tData[numTests] = data;
		tCount[numTests] = count;
		for (i = 0; i < int'(count); i++) begin
			if (op == OpWrite)
				modelMem[addr + addr_t'(i)] = data + word_t'(i);	// Address wraps
			else if (op == OpRead)
				tExp[numTests][i] = modelMem[addr + addr_t'(i)];
		end
		numTests++;
	endtask

	task automatic buildTable();
		addEntry("writeFour", OpWrite, 8'h10, 32'h11223344, 8'd4);
		addEntry("readFour", OpRead, 8'h10, 32'h0, 8'd4);
		addEntry("writeWrap", OpWrite, 8'd254, 32'hA0B0C0D0, 8'd4);
		addEntry("readWrap", OpRead, 8'd254, 32'h0, 8'd4);
		addEntry("overwritePart", OpWrite, 8'h12, nextRand(), 8'd2);
		addEntry("readMixed", OpRead, 8'h10, 32'h0, 8'd4);
		addEntry("unknownOp", 8'h05, 8'h10, nextRand(), 8'd4);
		addEntry("readAfterUnknown", OpRead, 8'h10, 32'h0, 8'd4);
		addEntry("readCountZero", OpRead, 8'h10, 32'h0, 8'd0);
		addEntry("writeRandA", OpWrite, 8'h80, nextRand(), 8'd6);
		addEntry("readRandA", OpRead, 8'h80, 32'h0, 8'd6);
		addEntry("writeRandB", OpWrite, 8'h40, nextRand(), 8'd3);
		addEntry("readRandB", OpRead, 8'h40, 32'h0, 8'd3);
		addEntry("readRandTail", OpRead, 8'h83, 32'h0, 8'd3);
	endtask

	// Serial host, one frame LSB first, called on a falling edge
	task automatic sendByte(input logic [ByteWidth-1:0] b);
		int i;
		uartRxd = 1'b0;	// Start bit
		repeat (ClocksPerBit) @(negedge sys_clk_p);
		for (i = 0; i < ByteWidth; i++) begin
			uartRxd = b[i];
			repeat (ClocksPerBit) @(negedge sys_clk_p);
		end
		uartRxd = 1'b1;
		repeat (ClocksPerBit) @(negedge sys_clk_p);
	endtask

	task automatic sendCommand(input logic [ByteWidth-1:0] op, input addr_t addr, input word_t data,
			input logic [ByteWidth-1:0] count);
		cmdWord_t frame;
		int b;
		frame.op = op;
		frame.addr = addr;
		frame.data = data;
		frame.count = count;
		for (b = CmdBytes - 1; b >= 0; b--)	// MSB first
			sendByte(frame[b*ByteWidth +: ByteWidth]);
	endtask

	task automatic getWord(output word_t w);
		int k;
		w = '0;
		for (k = 0; k < RespBytes; k++) begin
			while (respQueue.size() == 0)
				@(negedge sys_clk_p);
			w = {respQueue.pop_front(), w[WordWidth-1:ByteWidth]};	// LSB arrives first
		end
	endtask

	// ------------------------------------------------------------
	// Serial monitor, samples mid-bit on falling edges
	// ------------------------------------------------------------
	initial begin : serialMonitor
		logic [ByteWidth-1:0] b;
		int i;
		forever begin
			@(negedge sys_clk_p);
			if (rstN === 1'b1 && uartTxd === 1'b0) begin
				repeat (ClocksPerBit / 2) @(negedge sys_clk_p);
				for (i = 0; i < ByteWidth; i++) begin
					repeat (ClocksPerBit) @(negedge sys_clk_p);
					b[i] = uartTxd;
				end
				repeat (ClocksPerBit) @(negedge sys_clk_p);
				if (uartTxd !== 1'b1)
					abortRun("stop bit missing on uartTxd");
				else
					respQueue.push_back(b);
			end
		end
	end

	// Command engine checker
	always @(negedge sys_clk_p) begin
		if (dut.engine.chk.failCount != 0)
			abortRun("an assertion in the command engine failed");
	end

	initial begin : watchdog
		longint limit;
		int i;
		wait (tableReady === 1'b1);
		limit = 0;
		for (i = 0; i < numTests; i++)
			limit += longint'((CmdBytes + RespBytes * int'(tCount[i])) * 10 * ClocksPerBit * ClkPeriod);
		limit = 2 * limit + longint'(numTests * QuietCycles * ClkPeriod) + 1000;
		#(limit);
		abortRun("timeout waiting for response");
	end

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial begin : mainSeq
		int t;
		int w;
		word_t got;
		rstN = 1'b0;
		uartRxd = 1'b1;
		tableReady = 1'b0;
		numTests = 0;
		lcgState = Seed;
		buildTable();
		tableReady = 1'b1;
		repeat (2) @(posedge sys_clk_p);
		@(negedge sys_clk_p);
		rstN = 1'b1;
		repeat (4) @(negedge sys_clk_p);

		for (t = 0; t < numTests; t++) begin
			sendCommand(tOp[t], tAddr[t], tData[t], tCount[t]);
			if (tOp[t] == OpRead && tCount[t] != '0) begin
				for (w = 0; w < int'(tCount[t]); w++) begin
					getWord(got);
					checkWord($sformatf("%s word %0d", tName[t], w), tExp[t][w], got);
				end
			end else begin
				repeat (QuietCycles) @(negedge sys_clk_p);	// No reply expected
				if (respQueue.size() != 0)
					abortRun($sformatf("%s produced bytes on uartTxd", tName[t]));
			end
		end

		repeat (QuietCycles) @(negedge sys_clk_p);
		if (respQueue.size() != 0) begin
			abortRun("stray bytes on uartTxd at the end of the run");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* files.f */
logic/linkPkg.sv
logic/storePkg.sv
logic/storeIf.sv
logic/uartLink.sv
logic/shiftRound.sv
logic/cmdEngine.sv
logic/blockStore.sv
logic/oramHarnessTop.sv
tb/harness_assertions.sv
tb/harnessTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the harness testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module harnessTb -f files.f

# Keep running past a bound assertion so the testbench can report it
./obj_dir/VharnessTb +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi

if ! grep -q "Test completed successfully" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation PASSED"
